/* hw/bram_cfg_pkg.sv */
package bram_cfg_pkg;

    // ----------------------------------------------------------
    // read-out mode of the tiles
    // ----------------------------------------------------------
    typedef enum logic {
        OUT_DIRECT,         // data straight from the array latch
        OUT_REGISTERED      // extra output register stage
    } out_mode_t;

    // cycles from a sampled read to data on q
    function automatic int read_latency(input out_mode_t mode);
        if (mode == OUT_REGISTERED) begin
            return 2;
        end
        return 1;
    endfunction

endpackage

/* hw/bram_sdp.sv */
`timescale 1ns/1ps

module bram_sdp
    import bram_tile_pkg::*;
    import bram_cfg_pkg::*;
#(
    parameter int        DATA_WIDTH = 40,
    parameter int        ADDR_WIDTH = 11,
    parameter out_mode_t OUT_MODE   = OUT_REGISTERED
)(
    input  logic                  clk_rd,
    input  logic                  reset,
    // write port
    input  logic                  wren,
    input  logic [ADDR_WIDTH-1:0] wraddress,
    input  logic [DATA_WIDTH-1:0] data,
    // read port
    input  logic                  rden,
    input  logic [ADDR_WIDTH-1:0] rdaddress,
    output logic [DATA_WIDTH-1:0] q
);

    localparam int ROWS = row_count(ADDR_WIDTH);

    // ----------------------------------------------------------
    // decoder to grid control
    // ----------------------------------------------------------
    tile_ctrl_if #(
        .ROWS           (ROWS),
        .TILE_ADDR_BITS (TILE_ADDR_BITS)
    ) ctrl_if ();

    row_decoder #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .OUT_MODE   (OUT_MODE)
    ) row_decoder_i (
        .clk_rd    (clk_rd),
        .reset     (reset),
        .wren      (wren),
        .wraddress (wraddress),
        .rden      (rden),
        .rdaddress (rdaddress),
        .ctrl      (ctrl_if.decoder)
    );

    // write data goes straight to the grid
    tile_array #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .OUT_MODE   (OUT_MODE)
    ) tile_array_i (
        .clk_rd (clk_rd),
        .data   (data),
        .ctrl   (ctrl_if.array),
        .q      (q)
    );

endmodule

/* hw/bram_tile_pkg.sv */
package bram_tile_pkg;

    // ----------------------------------------------------------
    // primitive tile geometry
    // ----------------------------------------------------------
    localparam int TILE_WIDTH     = 16;     // data bits per tile
    localparam int TILE_ADDR_BITS = 9;      // 512 words per tile

    // ----------------------------------------------------------
    // tiling arithmetic
    // ----------------------------------------------------------
    // tile columns needed to cover the data word
    function automatic int col_count(input int data_width);
        return (data_width + TILE_WIDTH - 1) / TILE_WIDTH;
    endfunction

    // tile rows needed to cover the address space
    function automatic int row_count(input int addr_width);
        if (addr_width > TILE_ADDR_BITS) begin
            return 2 ** (addr_width - TILE_ADDR_BITS);
        end
        return 1;
    endfunction

    // width of the last, possibly narrower, column
    function automatic int last_col_width(input int data_width);
        return data_width - TILE_WIDTH * (col_count(data_width) - 1);
    endfunction

    // row index width, never below one bit
    function automatic int row_sel_bits(input int rows);
        return (rows > 1) ? $clog2(rows) : 1;
    endfunction

endpackage

/* hw/ram_tile.sv */
`timescale 1ns/1ps

module ram_tile
    import bram_cfg_pkg::*;
#(
    parameter int        WIDTH     = 16,
    parameter int        ADDR_BITS = 9,
    parameter out_mode_t OUT_MODE  = OUT_REGISTERED
)(
    input  logic                 clk_rd,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] wr_addr,
    input  logic [WIDTH-1:0]     wr_data,
    input  logic [ADDR_BITS-1:0] rd_addr,
    output logic [WIDTH-1:0]     rd_data
);

    logic [WIDTH-1:0] mem [2**ADDR_BITS];
    logic [WIDTH-1:0] mem_q;    // array output latch

    // ----------------------------------------------------------
    // storage, read every cycle
    // ----------------------------------------------------------
    always_ff @(posedge clk_rd) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        mem_q <= mem[rd_addr];  // old word on collision, read-first
    end

    // ----------------------------------------------------------
    // optional output register
    // ----------------------------------------------------------
    generate
        if (OUT_MODE == OUT_REGISTERED) begin : g_out_reg
            logic [WIDTH-1:0] out_q;

            always_ff @(posedge clk_rd) begin
                out_q <= mem_q;     // always enabled
            end
            assign rd_data = out_q;
        end else begin : g_direct
            assign rd_data = mem_q;
        end
    endgenerate

endmodule

/* hw/row_decoder.sv */
`timescale 1ns/1ps

module row_decoder
    import bram_tile_pkg::*;
    import bram_cfg_pkg::*;
#(
    parameter int        ADDR_WIDTH = 11,
    parameter out_mode_t OUT_MODE   = OUT_REGISTERED
)(
    input  logic                  clk_rd,
    input  logic                  reset,
    input  logic                  wren,
    input  logic [ADDR_WIDTH-1:0] wraddress,
    input  logic                  rden,
    input  logic [ADDR_WIDTH-1:0] rdaddress,
    tile_ctrl_if.decoder          ctrl
);

    localparam int ROWS     = row_count(ADDR_WIDTH);
    localparam int SEL_BITS = row_sel_bits(ROWS);
    localparam int LATENCY  = read_latency(OUT_MODE);
    // address bits that land inside a tile
    localparam int LOW_BITS = (ADDR_WIDTH < TILE_ADDR_BITS) ? ADDR_WIDTH : TILE_ADDR_BITS;

    logic [SEL_BITS-1:0] wr_row;
    logic [SEL_BITS-1:0] rd_row;
    logic [LOW_BITS-1:0] rd_low_hold;   // last read offset
    logic [LOW_BITS-1:0] rd_low;
    logic [SEL_BITS-1:0] sel_q [LATENCY];

    // ----------------------------------------------------------
    // row field of the flat addresses
    // ----------------------------------------------------------
    generate
        if (ROWS > 1) begin : g_rows
            assign wr_row = wraddress[ADDR_WIDTH-1:TILE_ADDR_BITS];
            assign rd_row = rdaddress[ADDR_WIDTH-1:TILE_ADDR_BITS];
        end else begin : g_one_row
            assign wr_row = '0;
            assign rd_row = '0;
        end
    endgenerate

    // one-hot row write enable
    always_comb begin
        ctrl.row_wen = '0;
        if (wren) begin
            ctrl.row_wen[wr_row] = 1'b1;
        end
    end

    assign ctrl.tile_wr_addr = TILE_ADDR_BITS'(wraddress[LOW_BITS-1:0]);

    // ----------------------------------------------------------
    // read address hold and row select pipeline
    // ----------------------------------------------------------
    always_ff @(posedge clk_rd or posedge reset) begin
        if (reset) begin
            rd_low_hold <= '0;
            for (int i = 0; i < LATENCY; i++) begin
                sel_q[i] <= '0;
            end
        end else begin
            if (rden) begin
                rd_low_hold <= rdaddress[LOW_BITS-1:0];
                sel_q[0]    <= rd_row;      // row stays put while idle
            end
            for (int i = 1; i < LATENCY; i++) begin
                sel_q[i] <= sel_q[i-1];     // follows the tile out reg
            end
        end
    end

    assign rd_low            = rden ? rdaddress[LOW_BITS-1:0] : rd_low_hold;
    assign ctrl.tile_rd_addr = TILE_ADDR_BITS'(rd_low);
    assign ctrl.rd_sel       = sel_q[LATENCY-1];

endmodule

/* hw/tile_array.sv */
`timescale 1ns/1ps

module tile_array
    import bram_tile_pkg::*;
    import bram_cfg_pkg::*;
#(
    parameter int        DATA_WIDTH = 40,
    parameter int        ADDR_WIDTH = 11,
    parameter out_mode_t OUT_MODE   = OUT_REGISTERED
)(
    input  logic                  clk_rd,
    input  logic [DATA_WIDTH-1:0] data,
    tile_ctrl_if.array            ctrl,
    output logic [DATA_WIDTH-1:0] q
);

    localparam int ROWS       = row_count(ADDR_WIDTH);
    localparam int COLS       = col_count(DATA_WIDTH);
    localparam int LAST_WIDTH = last_col_width(DATA_WIDTH);

    // read word gathered per row
    logic [ROWS-1:0][DATA_WIDTH-1:0] row_q;

    // ----------------------------------------------------------
    // tile grid
    // ----------------------------------------------------------
    // every tile of a row shares that row's write enable;
    // every tile of a column sees the same slice of data
    generate
        for (genvar r = 0; r < ROWS; r++) begin : g_row
            for (genvar c = 0; c < COLS; c++) begin : g_col
                localparam int W   = (c == COLS - 1) ? LAST_WIDTH : TILE_WIDTH;
                localparam int LSB = c * TILE_WIDTH;

                ram_tile #(
                    .WIDTH     (W),
                    .ADDR_BITS (TILE_ADDR_BITS),
                    .OUT_MODE  (OUT_MODE)
                ) tile_i (
                    .clk_rd  (clk_rd),
                    .we      (ctrl.row_wen[r]),
                    .wr_addr (ctrl.tile_wr_addr),
                    .wr_data (data[LSB +: W]),
                    .rd_addr (ctrl.tile_rd_addr),
                    .rd_data (row_q[r][LSB +: W])
                );
            end
        end
    endgenerate

    // ----------------------------------------------------------
    // output row select
    // ----------------------------------------------------------
    // rd_sel is already delayed to match the tile latency,
    // so this stays a plain mux
    assign q = row_q[ctrl.rd_sel];

endmodule

/* hw/tile_ctrl_if.sv */
`timescale 1ns/1ps

interface tile_ctrl_if
    import bram_tile_pkg::*;
#(
    parameter int ROWS           = 4,
    parameter int TILE_ADDR_BITS = 9
);

    logic [ROWS-1:0]                 row_wen;       // one-hot write enable per row
    logic [TILE_ADDR_BITS-1:0]       tile_wr_addr;  // shared by all tiles
    logic [TILE_ADDR_BITS-1:0]       tile_rd_addr;  // live or held read address
    logic [row_sel_bits(ROWS)-1:0]   rd_sel;        // aligned with tile output

    // decoder side drives everything
    modport decoder (
        output row_wen, tile_wr_addr, tile_rd_addr, rd_sel
    );

    // tile grid only consumes
    modport array (
        input row_wen, tile_wr_addr, tile_rd_addr, rd_sel
    );

endinterface

/* list.f */
hw/bram_tile_pkg.sv
hw/bram_cfg_pkg.sv
hw/tile_ctrl_if.sv
hw/ram_tile.sv
hw/row_decoder.sv
hw/tile_array.sv
hw/bram_sdp.sv
test/bram_sdp_assert.sv
test/bram_sdp_tb.sv

/* run.sh */
#!/bin/sh
# build and run the bram_sdp testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module bram_sdp_tb \
    -f list.f \
    -o bram_sdp_sim

./obj_dir/bram_sdp_sim

/* test/bram_sdp_assert.sv */
`timescale 1ns/1ps

module bram_sdp_assert #(
    parameter int ROWS      = 4,
    parameter int ADDR_BITS = 9
)(
    input logic                 clk_rd,
    input logic                 reset,
    input logic                 wren,
    input logic                 rden,
    input logic [ROWS-1:0]      row_wen,
    input logic [ADDR_BITS-1:0] tile_rd_addr
);

    // ----------------------------------------------------------
    // row decode and read address hold
    // ----------------------------------------------------------
    row_wen_onehot: assert property (
        @(posedge clk_rd) disable iff (reset) $onehot0(row_wen)
    ) else $error("row_wen has more than one row enabled: %b", row_wen);

    row_wen_gated: assert property (
        @(posedge clk_rd) disable iff (reset) !wren |-> (row_wen == '0)
    ) else $error("row_wen set without wren: %b", row_wen);

    // idle cycle keeps the address of the previous cycle
    rd_addr_held: assert property (
        @(posedge clk_rd) disable iff (reset)
        !rden |-> $stable(tile_rd_addr)
    ) else $error("tile_rd_addr changed while rden was low");

endmodule

bind row_decoder bram_sdp_assert #(
    .ROWS      (ROWS),
    .ADDR_BITS (TILE_ADDR_BITS)
) assert_i (
    .clk_rd       (clk_rd),
    .reset        (reset),
    .wren         (wren),
    .rden         (rden),
    .row_wen      (ctrl.row_wen),
    .tile_rd_addr (ctrl.tile_rd_addr)
);

/* test/bram_sdp_tb.sv */
`timescale 1ns/1ps

module bram_sdp_tb
    import bram_tile_pkg::*;
    import bram_cfg_pkg::*;
();

    localparam int        DATA_WIDTH = 40;
    localparam int        ADDR_WIDTH = 11;
    localparam out_mode_t OUT_MODE   = OUT_REGISTERED;
    localparam int        DEPTH      = 2 ** ADDR_WIDTH;
    localparam int        ROWS       = row_count(ADDR_WIDTH);
    localparam int        ROW_WORDS  = 2 ** TILE_ADDR_BITS;
    localparam int        LAT        = read_latency(OUT_MODE);
    // 2048 writes + 2048 reads + a few hundred short test cycles, well under
    localparam int        MAX_CYCLES = 12000;

    logic                  clk_rd;
    logic                  reset;
    logic                  wren;
    logic [ADDR_WIDTH-1:0] wraddress;
    logic [DATA_WIDTH-1:0] data;
    logic                  rden;
    logic [ADDR_WIDTH-1:0] rdaddress;
    logic [DATA_WIDTH-1:0] q;

    logic [DATA_WIDTH-1:0] model [DEPTH];   // reference memory
    int                    due_q [$];       // cycle at which q is checked
    logic [DATA_WIDTH-1:0] exp_q [$];
    logic [ADDR_WIDTH-1:0] addr_q [$];
    int                    cycle = 0;

    bram_sdp bram_sdp_i (
        .clk_rd    (clk_rd),
        .reset     (reset),
        .wren      (wren),
        .wraddress (wraddress),
        .data      (data),
        .rden      (rden),
        .rdaddress (rdaddress),
        .q         (q)
    );

    always #2 clk_rd = ~clk_rd;

    always @(posedge clk_rd) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d clock cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [DATA_WIDTH-1:0] random_word();
        return DATA_WIDTH'({$urandom(), $urandom()});
    endfunction

    // one clock, then compare every read that is due now
    task automatic tick();
        @(posedge clk_rd);
        #0.5;
        while (due_q.size() > 0 && due_q[0] == cycle) begin
            check_value($sformatf("q (rdaddress %h)", addr_q[0]), q, exp_q[0]);
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
            void'(addr_q.pop_front());
        end
    endtask

    task automatic expect_word(input logic [ADDR_WIDTH-1:0] addr);
        due_q.push_back(cycle + LAT);
        exp_q.push_back(model[addr]);
        addr_q.push_back(addr);
    endtask

    task automatic issue_read(input logic [ADDR_WIDTH-1:0] addr);
        rden      = 1'b1;
        rdaddress = addr;
        expect_word(addr);      // old word, before any write this cycle
    endtask

    task automatic issue_write(input logic [ADDR_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] val);
        wren      = 1'b1;
        wraddress = addr;
        data      = val;
        model[addr] = val;
    endtask

    task automatic quiet();
        wren = 1'b0;
        rden = 1'b0;
    endtask

    task automatic drain();
        quiet();
        while (due_q.size() > 0) begin
            tick();
        end
    endtask

    // ----------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------
    task automatic fill_and_read();
        for (int a = 0; a < DEPTH; a++) begin
            issue_write(ADDR_WIDTH'(a), random_word());
            tick();
        end
        quiet();
        for (int a = 0; a < DEPTH; a++) begin
            issue_read(ADDR_WIDTH'(a));
            tick();
        end
        drain();
    endtask

    task automatic pipelined_reads();
        for (int i = 0; i < 16; i++) begin
            issue_read(ADDR_WIDTH'((i % ROWS) * ROW_WORDS + (i * 37) % ROW_WORDS));
            tick();
        end
        drain();
    endtask

    task automatic hold_output();
        logic [ADDR_WIDTH-1:0] addr;
        addr = ADDR_WIDTH'(2 * ROW_WORDS + 211);
        issue_read(addr);
        tick();
        rden      = 1'b0;
        rdaddress = addr ^ ADDR_WIDTH'(5);  // must be ignored while idle
        for (int i = 0; i < 8; i++) begin
            expect_word(addr);
            tick();
        end
        drain();
    endtask

    task automatic read_first_collision();
        logic [ADDR_WIDTH-1:0] addr;
        addr = ADDR_WIDTH'(3 * ROW_WORDS + 100);
        issue_read(addr);
        issue_write(addr, random_word());
        tick();
        quiet();
        issue_read(addr);       // new word now
        tick();
        drain();
    endtask

    task automatic row_col_isolation();
        int offset;
        offset = 37;
        issue_write(ADDR_WIDTH'(ROW_WORDS + offset), '1);
        tick();
        quiet();
        for (int r = 0; r < ROWS; r++) begin
            issue_read(ADDR_WIDTH'(r * ROW_WORDS + offset));
            tick();
        end
        issue_read(ADDR_WIDTH'(ROW_WORDS + offset + 1));   // neighbour in same row
        tick();
        drain();
    endtask

    initial begin
        void'($urandom(32'h91ce259b));
        clk_rd    = 1'b0;
        reset     = 1'b1;
        wren      = 1'b0;
        wraddress = '0;
        data      = '0;
        rden      = 1'b0;
        rdaddress = '0;
        repeat (4) @(posedge clk_rd);
        #0.5;
        reset = 1'b0;

        fill_and_read();
        pipelined_reads();
        hold_output();
        read_first_collision();
        row_col_isolation();

        $display("Simulation PASSED");
        $finish;
    end

endmodule
